// ==== decodePkg.sv ====
package decodePkg;

    // Widths with a meaning of their own
    typedef logic [31:0] insWord;
    typedef logic [4:0]  regAddr;
    typedef logic [1:0]  tCount;
    typedef logic [3:0]  aluOp;
    typedef logic [2:0]  mduOp;
    typedef logic [1:0]  memWidth;
    typedef logic [1:0]  resSel;

    // ALU operation codes
    localparam aluOp ALU_ADD  = 4'd0;
    localparam aluOp ALU_SUB  = 4'd1;
    localparam aluOp ALU_AND  = 4'd2;
    localparam aluOp ALU_OR   = 4'd3;
    localparam aluOp ALU_LUI  = 4'd4;
    localparam aluOp ALU_SLT  = 4'd5;
    localparam aluOp ALU_SLTU = 4'd6;

    // Multiply/divide codes
    localparam mduOp MDU_MULT  = 3'd0;
    localparam mduOp MDU_MULTU = 3'd1;
    localparam mduOp MDU_DIV   = 3'd2;
    localparam mduOp MDU_DIVU  = 3'd3;

    // Data memory access widths
    localparam memWidth WIDTH_WORD = 2'd0;
    localparam memWidth WIDTH_HALF = 2'd1;
    localparam memWidth WIDTH_BYTE = 2'd2;

    // E-stage result select
    localparam resSel RES_NONE = 2'd0;
    localparam resSel RES_ALU  = 2'd1;
    localparam resSel RES_HI   = 2'd2;
    localparam resSel RES_LO   = 2'd3;

    typedef struct packed {
        logic    npcJr;
        logic    npcJ;
        logic    npcBranch;
        logic    npcBezal;
        logic    cmpSel;
        logic    isMdft;
        logic    linkSel;
        regAddr  a3;
        tCount   tuseRs;
        tCount   tuseRt;
        tCount   tnew;
        logic    aluBSrc;
        logic    immSext;
        aluOp    aluSel;
        logic    mduStart;
        mduOp    mduSel;
        logic    hiWrite;
        logic    loWrite;
        resSel   resSelE;
        logic    dmWe;
        memWidth dmWidth;
        logic    loadSel;
        logic    readsRs;
        logic    readsRt;
    } ctrlWord;

    typedef struct packed {
        insWord  ins;
        ctrlWord ctrl;
    } issuePkt;

    typedef struct packed {
        logic fwdEn;
    } hazCfg;

endpackage

// ==== Controller.sv ====
`timescale 1ns/1ps

module Controller (
    input  decodePkg::insWord  ins,
    output decodePkg::ctrlWord ctrl
);
    import decodePkg::*;

    logic [5:0] op;
    logic [5:0] func;
    regAddr     rt;
    regAddr     rd;
    logic       rType;

    // Individual instructions
    logic add, sub, andR, orR, slt, sltu;
    logic mult, multu, div, divu;
    logic mfhi, mflo, mthi, mtlo;
    logic jr, jalr, bezal;
    logic addi, andi, ori, lui;
    logic beq, bne;
    logic lw, lh, lb;
    logic sw, sh, sb;
    logic j, jal;

    // Instruction classes
    logic isCalR, isMd, isMf, isMt, isJReg;
    logic isCalI, isBranch, isLoad, isStore;
    logic isLink, isJ;

    assign op    = ins[31:26];
    assign func  = ins[5:0];
    assign rt    = ins[20:16];
    assign rd    = ins[15:11];
    assign rType = (op == 6'b000000);

    // Special opcode, selected by function field
    assign add   = rType && (func == 6'b100000);
    assign sub   = rType && (func == 6'b100010);
    assign andR  = rType && (func == 6'b100100);
    assign orR   = rType && (func == 6'b100101);
    assign slt   = rType && (func == 6'b101010);
    assign sltu  = rType && (func == 6'b101011);
    assign mult  = rType && (func == 6'b011000);
    assign multu = rType && (func == 6'b011001);
    assign div   = rType && (func == 6'b011010);
    assign divu  = rType && (func == 6'b011011);
    assign mfhi  = rType && (func == 6'b010000);
    assign mflo  = rType && (func == 6'b010010);
    assign mthi  = rType && (func == 6'b010001);
    assign mtlo  = rType && (func == 6'b010011);
    assign jr    = rType && (func == 6'b001000);
    assign jalr  = rType && (func == 6'b001001);
    assign bezal = rType && (func == 6'b111101);

    // Immediate and jump opcodes
    assign addi = (op == 6'b001000);
    assign andi = (op == 6'b001100);
    assign ori  = (op == 6'b001101);
    assign lui  = (op == 6'b001111);
    assign beq  = (op == 6'b000100);
    assign bne  = (op == 6'b000101);
    assign lw   = (op == 6'b100011);
    assign lh   = (op == 6'b100001);
    assign lb   = (op == 6'b100000);
    assign sw   = (op == 6'b101011);
    assign sh   = (op == 6'b101001);
    assign sb   = (op == 6'b101000);
    assign j    = (op == 6'b000010);
    assign jal  = (op == 6'b000011);

    assign isCalR   = add || sub || andR || orR || slt || sltu;
    assign isMd     = mult || multu || div || divu;
    assign isMf     = mfhi || mflo;
    assign isMt     = mthi || mtlo;
    assign isJReg   = jr || jalr;
    assign isCalI   = addi || andi || ori || lui;
    assign isBranch = beq || bne;
    assign isLoad   = lw || lh || lb;
    assign isStore  = sw || sh || sb;
    assign isLink   = jal || jalr;
    assign isJ      = j || jal;

    always_comb begin
        ctrl = '0;

        ctrl.npcJr     = isJReg;
        ctrl.npcJ      = isJ;
        ctrl.npcBranch = isBranch;
        ctrl.npcBezal  = bezal;
        // Compare unit checks for inequality on bne
        ctrl.cmpSel    = bne;
        ctrl.isMdft    = isMd || isMf || isMt;
        ctrl.linkSel   = isLink;

        if (isCalR || isMf) begin
            ctrl.a3 = rd;
        end else if (isCalI || isLoad) begin
            ctrl.a3 = rt;
        end else if (isLink) begin
            ctrl.a3 = 5'd31;
        end

        // Tuse of 3 means the operand is not needed in time
        if (isJReg || isBranch || bezal) begin
            ctrl.tuseRs = 2'd0;
        end else if (isCalR || isMd || isMt || isCalI || isLoad || isStore) begin
            ctrl.tuseRs = 2'd1;
        end else begin
            ctrl.tuseRs = 2'd3;
        end

        if (isBranch || bezal) begin
            ctrl.tuseRt = 2'd0;
        end else if (isCalR || isMd) begin
            ctrl.tuseRt = 2'd1;
        end else if (isStore) begin
            ctrl.tuseRt = 2'd2;
        end else begin
            ctrl.tuseRt = 2'd3;
        end

        if (isLoad) begin
            ctrl.tnew = 2'd3;
        end else if (isCalR || isMf || isCalI) begin
            ctrl.tnew = 2'd2;
        end else if (isLink) begin
            ctrl.tnew = 2'd1;
        end

        ctrl.aluBSrc = isCalI || isLoad || isStore;
        ctrl.immSext = addi || isLoad || isStore;
        if (sub) begin
            ctrl.aluSel = ALU_SUB;
        end else if (andR || andi) begin
            ctrl.aluSel = ALU_AND;
        end else if (orR || ori) begin
            ctrl.aluSel = ALU_OR;
        end else if (lui) begin
            ctrl.aluSel = ALU_LUI;
        end else if (slt) begin
            ctrl.aluSel = ALU_SLT;
        end else if (sltu) begin
            ctrl.aluSel = ALU_SLTU;
        end else begin
            ctrl.aluSel = ALU_ADD;
        end

        ctrl.mduStart = isMd;
        ctrl.mduSel   = divu ? MDU_DIVU : div ? MDU_DIV : multu ? MDU_MULTU : MDU_MULT;
        ctrl.hiWrite  = mthi;
        ctrl.loWrite  = mtlo;
        ctrl.resSelE  = mflo ? RES_LO : mfhi ? RES_HI :
                        (isCalR || isCalI) ? RES_ALU : RES_NONE;

        ctrl.dmWe    = isStore;
        ctrl.dmWidth = (sb || lb) ? WIDTH_BYTE : (sh || lh) ? WIDTH_HALF : WIDTH_WORD;
        ctrl.loadSel = isLoad;

        ctrl.readsRs = isCalR || isMd || isMt || isJReg || isCalI || isBranch ||
                       isLoad || isStore || bezal;
        ctrl.readsRt = isCalR || isMd || isBranch || isStore || bezal;
    end

endmodule

// ==== insQueue.sv ====
`timescale 1ns/1ps

module insQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              insValid,
    input  decodePkg::insWord ins,
    input  logic              pop,
    output decodePkg::insWord head,
    output logic              empty,
    output logic              insCredit
);
    import decodePkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    insWord             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Writes past a full queue are dropped
    assign push  = insValid && (count != CNT_W'(QUEUE_DEPTH));
    assign doPop = pop && !empty;
    assign empty = (count == '0);
    assign head  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= ins;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            insCredit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count     <= count + CNT_W'(push) - CNT_W'(doPop);
            // One credit back to fetch, a cycle after the pop
            insCredit <= doPop;
        end
    end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  logic               clk,
    input  logic               rstN,
    input  decodePkg::ctrlWord ctrl,
    input  decodePkg::regAddr  rs,
    input  decodePkg::regAddr  rt,
    input  logic               fire,
    input  logic               fwdEn,
    output logic               stall
);
    import decodePkg::*;

    localparam int STAGES = 3;

    // Index 0 is E, 1 is M, 2 is W
    regAddr dstQ  [STAGES];
    tCount  tnewQ [STAGES];

    logic rsHit;
    logic rtHit;

    function automatic tCount tickDown(input tCount t);
        return (t == 2'd0) ? 2'd0 : t - 2'd1;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < STAGES; i++) begin
                dstQ[i]  <= '0;
                tnewQ[i] <= '0;
            end
        end else begin
            // Bubble into E when nothing issues
            if (fire) begin
                dstQ[0]  <= ctrl.a3;
                tnewQ[0] <= tickDown(ctrl.tnew);
            end else begin
                dstQ[0]  <= '0;
                tnewQ[0] <= '0;
            end
            for (int i = 1; i < STAGES; i++) begin
                dstQ[i]  <= dstQ[i-1];
                tnewQ[i] <= tickDown(tnewQ[i-1]);
            end
        end
    end

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            rsHit = ctrl.readsRs && (rs != '0) && (dstQ[i] == rs);
            rtHit = ctrl.readsRt && (rt != '0) && (dstQ[i] == rt);
            if (fwdEn) begin
                // Forwarding covers the result once it is ready by Tuse
                if (rsHit && (tnewQ[i] > ctrl.tuseRs)) begin
                    stall = 1'b1;
                end
                if (rtHit && (tnewQ[i] > ctrl.tuseRt)) begin
                    stall = 1'b1;
                end
            end else if (rsHit || rtHit) begin
                // No bypass, so wait until the writer leaves W
                stall = 1'b1;
            end
        end
    end

endmodule

// ==== hazardConfig.sv ====
`timescale 1ns/1ps

module hazardConfig (
    input  logic             clk,
    input  logic             rstN,
    input  logic             cfgWe,
    input  decodePkg::hazCfg cfgWdata,
    input  logic             stall,
    output decodePkg::hazCfg cfg,
    output logic [15:0]      stallCount
);
    import decodePkg::*;

    hazCfg cfgQ;

    assign cfg = cfgQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // Forwarding assumed out of reset
            cfgQ.fwdEn <= 1'b1;
            stallCount <= '0;
        end else begin
            if (cfgWe) begin
                cfgQ <= cfgWdata;
            end
            // Saturates rather than wraps
            if (stall && (stallCount != '1)) begin
                stallCount <= stallCount + 16'd1;
            end
        end
    end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               insValid,
    input  decodePkg::insWord  ins,
    output logic               insCredit,
    output logic               issueValid,
    output decodePkg::issuePkt issue,
    input  logic               outCredit,
    input  logic               cfgWe,
    input  decodePkg::hazCfg   cfgWdata,
    output decodePkg::hazCfg   cfgRdata,
    output logic [15:0]        stallCount
);
    import decodePkg::*;

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    insWord              head;
    logic                empty;
    ctrlWord             ctrl;
    logic                stall;
    logic                fire;
    logic [CRED_W-1:0]   credits;

    assign fire = !empty && !stall && (credits != '0);

    insQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk      (clk),
        .rstN     (rstN),
        .insValid (insValid),
        .ins      (ins),
        .pop      (fire),
        .head     (head),
        .empty    (empty),
        .insCredit(insCredit)
    );

    Controller u_ctrl (
        .ins (head),
        .ctrl(ctrl)
    );

    hazardUnit u_hazard (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl),
        .rs   (head[25:21]),
        .rt   (head[20:16]),
        .fire (fire),
        .fwdEn(cfgRdata.fwdEn),
        .stall(stall)
    );

    // Only count stalls that hold back a real instruction
    hazardConfig u_hazCfg (
        .clk       (clk),
        .rstN      (rstN),
        .cfgWe     (cfgWe),
        .cfgWdata  (cfgWdata),
        .stall     (stall && !empty),
        .cfg       (cfgRdata),
        .stallCount(stallCount)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits    <= CRED_W'(OUT_CREDITS);
            issueValid <= 1'b0;
        end else begin
            credits    <= credits + CRED_W'(outCredit) - CRED_W'(fire);
            issueValid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue.ins  <= head;
            issue.ctrl <= ctrl;
        end
    end

endmodule

// ==== decodeStage_props.sv ====
`timescale 1ns/1ps

module decodeStage_props #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic                                 clk,
    input logic                                 rstN,
    input logic                                 insValid,
    input logic                                 outCredit,
    input logic                                 issueValid,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]     queueCount
);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Credits granted by the back end minus packets seen on the issue port
    int balance;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            balance <= OUT_CREDITS;
        end else begin
            balance <= balance + int'(outCredit) - int'(issueValid);
        end
    end

    // A credit returned in the cycle before issueValid is too late for that packet
    noIssueWithoutCredit: assert property (@(posedge clk) disable iff (!rstN)
        issueValid |-> (balance > int'($past(outCredit))))
        else $error("Issue sent with no output credit left");

    // Fetch must hold a credit, so the queue is never full on a push
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        insValid |-> (queueCount != CNT_W'(QUEUE_DEPTH)))
        else $error("Instruction word sent while the queue was full");

    issueLowInReset: assert property (@(posedge clk)
        !rstN |-> !issueValid)
        else $error("issueValid high during reset");

endmodule

bind decodeStage decodeStage_props #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
) props_i (
    .clk       (clk),
    .rstN      (rstN),
    .insValid  (insValid),
    .outCredit (outCredit),
    .issueValid(issueValid),
    .queueCount(u_queue.count)
);

// ==== decodeStage_tb.sv ====
`timescale 1ns/1ps

module decodeStage_tb;
    import decodePkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_LINES     = 20;
    localparam int COLS        = 8;
    // Lines before this run with forwarding, the rest without
    localparam int SPLIT       = 10;
    localparam int HOLD_CYCLES = 20;
    localparam int CYCLE_LIMIT = 40 * N_LINES;

    // Golden file columns
    localparam int C_INS   = 0;
    localparam int C_ALU   = 1;
    localparam int C_A3    = 2;
    localparam int C_TNEW  = 3;
    localparam int C_WIDTH = 4;
    localparam int C_STORE = 5;
    localparam int C_DEP   = 6;
    localparam int C_TUSE  = 7;

    logic        clk;
    logic        rstN;
    logic        insValid;
    insWord      ins;
    logic        insCredit;
    logic        issueValid;
    issuePkt     issue;
    logic        outCredit;
    logic        cfgWe;
    hazCfg       cfgWdata;
    hazCfg       cfgRdata;
    logic [15:0] stallCount;

    logic [31:0] gold [N_LINES*COLS];

    int          cycleCount;
    int          sent;
    int          issued;
    int          queued;
    int          credits;
    int          inCredits;
    int          modelStalls;
    int          phase;
    int          idle;
    int          stallAtSwitch;
    int          shDst [3];
    int          shTnew [3];
    int          issueCycle [N_LINES];
    int          creditDue [$];
    bit          modelFwd;
    bit          lastIns;
    bit          lastCred;
    bit          lastCfgWe;
    bit          fired;
    bit          expFire;
    bit          stallNow;
    bit          done;

    decodeStage #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) decodeStage_i (
        .clk       (clk),
        .rstN      (rstN),
        .insValid  (insValid),
        .ins       (ins),
        .insCredit (insCredit),
        .issueValid(issueValid),
        .issue     (issue),
        .outCredit (outCredit),
        .cfgWe     (cfgWe),
        .cfgWdata  (cfgWdata),
        .cfgRdata  (cfgRdata),
        .stallCount(stallCount)
    );

    always #50 clk = ~clk;

    function automatic int goldField(input int line, input int col);
        return int'(gold[line*COLS+col]);
    endfunction

    function automatic int countDown(input int t);
        return (t > 0) ? t - 1 : 0;
    endfunction

    // Head depends only on the line before it, by construction of the golden stream
    function automatic bit headStalls(input int idx, input bit fwd);
        int depReg;
        bit hit;
        hit = 1'b0;
        if (idx > 0 && goldField(idx, C_DEP) != 0) begin
            depReg = goldField(idx - 1, C_A3);
            for (int s = 0; s < 3; s++) begin
                if (depReg != 0 && shDst[s] == depReg &&
                    (!fwd || shTnew[s] > goldField(idx, C_TUSE))) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // Issue spacing of a dependent pair, from the stall rule
    function automatic int minGap(input int prodTnew, input int tuse, input bit fwd);
        int waitCycles;
        if (!fwd) begin
            waitCycles = 3;
        end else begin
            waitCycles = (prodTnew - 1 > tuse) ? prodTnew - 1 - tuse : 0;
        end
        return 1 + waitCycles;
    endfunction

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic verifyIssue(input int idx);
        int need;
        int gap;
        expectEqual("issue.ins", issue.ins, gold[idx*COLS+C_INS]);
        expectEqual("issue.ctrl.aluSel", 32'(issue.ctrl.aluSel), goldField(idx, C_ALU));
        expectEqual("issue.ctrl.a3", 32'(issue.ctrl.a3), goldField(idx, C_A3));
        expectEqual("issue.ctrl.tnew", 32'(issue.ctrl.tnew), goldField(idx, C_TNEW));
        expectEqual("issue.ctrl.dmWidth", 32'(issue.ctrl.dmWidth), goldField(idx, C_WIDTH));
        expectEqual("issue.ctrl.dmWe", 32'(issue.ctrl.dmWe), goldField(idx, C_STORE));
        issueCycle[idx] = cycleCount;
        if (idx > 0 && goldField(idx, C_DEP) != 0) begin
            need = minGap(goldField(idx - 1, C_TNEW), goldField(idx, C_TUSE), idx < SPLIT);
            gap  = cycleCount - issueCycle[idx - 1];
            expectEqual("dependent issue gap", (gap >= need) ? need : gap, need);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        insValid  = 1'b0;
        ins       = '0;
        outCredit = 1'b0;
        cfgWe     = 1'b0;
        cfgWdata  = '0;
        void'($urandom(89));

        cycleCount  = 0;
        sent        = 0;
        issued      = 0;
        queued      = 0;
        credits     = OUT_CREDITS;
        inCredits   = QUEUE_DEPTH;
        modelStalls = 0;
        phase       = 0;
        idle        = 0;
        modelFwd    = 1'b1;
        lastIns     = 1'b0;
        lastCred    = 1'b0;
        lastCfgWe   = 1'b0;
        done        = 1'b0;
        for (int s = 0; s < 3; s++) begin
            shDst[s]  = 0;
            shTnew[s] = 0;
        end

        for (int i = 0; i < N_LINES * COLS; i++) begin
            gold[i] = '1;
        end
        $readmemh("decodeStage_golden.txt", gold);
        if (gold[N_LINES*COLS-1] === '1) begin
            $display("Golden file is missing or shorter than %0d lines", N_LINES);
            $display("sim failed");
            $fatal(1, "bad golden file");
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        while (!done) begin
            @(negedge clk);
            cycleCount++;
            if (cycleCount > CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles with %0d of %0d words issued",
                         CYCLE_LIMIT, issued, N_LINES);
                $display("sim failed");
                $fatal(1, "timeout");
            end

            // issueValid now shows the fire decision of the previous cycle
            fired = issueValid;
            if (insCredit) begin
                inCredits++;
            end
            expFire  = 1'b0;
            stallNow = 1'b0;
            if (queued > 0) begin
                stallNow = headStalls(issued, modelFwd);
                if (stallNow) begin
                    modelStalls++;
                end
                expFire = !stallNow && (credits > 0);
            end
            expectEqual("issueValid", 32'(fired), 32'(expFire));
            if (fired) begin
                verifyIssue(issued);
                creditDue.push_back(cycleCount + int'($urandom_range(3, 0)));
            end

            // Advance the model by one cycle
            shDst[2]  = shDst[1];
            shTnew[2] = countDown(shTnew[1]);
            shDst[1]  = shDst[0];
            shTnew[1] = countDown(shTnew[0]);
            if (fired) begin
                shDst[0]  = goldField(issued, C_A3);
                shTnew[0] = countDown(goldField(issued, C_TNEW));
                issued++;
            end else begin
                shDst[0]  = 0;
                shTnew[0] = 0;
            end
            queued  = queued + int'(lastIns) - int'(fired);
            credits = credits + int'(lastCred) - int'(fired);
            if (lastCfgWe) begin
                // Only write in the run clears fwdEn
                modelFwd = 1'b0;
            end

            if (cycleCount == HOLD_CYCLES) begin
                expectEqual("issues during credit hold", issued, OUT_CREDITS);
            end

            insValid  = 1'b0;
            outCredit = 1'b0;
            cfgWe     = 1'b0;
            if (phase == 0 && issued == SPLIT) begin
                idle++;
                // Shadow stages are empty again
                if (idle >= 4) begin
                    cfgWe          = 1'b1;
                    cfgWdata.fwdEn = 1'b0;
                    phase          = 1;
                end
            end else if (phase == 1) begin
                expectEqual("cfgRdata.fwdEn", 32'(cfgRdata.fwdEn), 32'd0);
                stallAtSwitch = int'(stallCount);
                phase         = 2;
                idle          = 0;
            end else if (phase == 2 && issued == N_LINES) begin
                idle++;
                done = (idle >= 4);
            end

            if (sent < ((phase == 2) ? N_LINES : SPLIT) && inCredits > 0) begin
                insValid = 1'b1;
                ins      = gold[sent*COLS+C_INS];
                sent++;
                inCredits--;
            end
            if (cycleCount >= HOLD_CYCLES && creditDue.size() > 0 &&
                creditDue[0] <= cycleCount) begin
                outCredit = 1'b1;
                void'(creditDue.pop_front());
            end
            lastIns   = insValid;
            lastCred  = outCredit;
            lastCfgWe = cfgWe;
        end

        expectEqual("input credits returned", inCredits, QUEUE_DEPTH);
        expectEqual("stalls without forwarding", 32'(int'(stallCount) > stallAtSwitch), 32'd1);
        expectEqual("stallCount", 32'(stallCount), modelStalls);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== decodeStage_golden.txt ====
// ins alu a3 tnew width store dep tuse (hex, one instruction per line)
// dep marks a read of the previous line's destination, tuse is that operand's use time
02950820 0 01 2 0 0 0 0 // add  $1,$20,$21
8E820004 0 02 3 0 0 0 0 // lw   $2,4($20)
00551820 0 03 2 0 0 1 1 // add  $3,$2,$21
00742022 1 04 2 0 0 1 1 // sub  $4,$3,$20
36C500FF 3 05 2 0 0 0 0 // ori  $5,$22,0xff
AE850008 0 00 0 0 1 1 2 // sw   $5,8($20)
82A60001 0 06 3 2 0 0 0 // lb   $6,1($21)
A6860002 0 00 0 1 1 1 2 // sh   $6,2($20)
3C071234 4 07 2 0 0 0 0 // lui  $7,0x1234
00F6402A 5 08 2 0 0 1 1 // slt  $8,$7,$22
32890F0F 2 09 2 0 0 0 0 // andi $9,$20,0x0f0f
01355024 2 0A 2 0 0 1 1 // and  $10,$9,$21
0295582B 6 0B 2 0 0 0 0 // sltu $11,$20,$21
FFFFFFFF 0 00 0 0 0 0 0 // unknown word
86CC0006 0 0C 3 1 0 0 0 // lh   $12,6($22)
A2AC0003 0 00 0 2 1 1 2 // sb   $12,3($21)
0C000100 0 1F 1 0 0 0 0 // jal  0x100
02966825 3 0D 2 0 0 0 0 // or   $13,$20,$22
21AEFFFF 0 0E 2 0 0 1 1 // addi $14,$13,-1
02B60018 0 00 0 0 0 0 0 // mult $21,$22

// ==== compile.f ====
decodePkg.sv
Controller.sv
insQueue.sv
hazardUnit.sv
hazardConfig.sv
decodeStage.sv
decodeStage_props.sv
decodeStage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module decodeStage_tb -o decodeStage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decodeStage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
